/* Bender.yml */
package:
  name: mips_sys

sources:
  - include_dirs:
      - include
    files:
      - source/mipsPkg.sv
      - source/slaveIf.sv
      - source/dataMem.sv
      - source/timer.sv
      - source/southBridge.sv
      - source/northBridge.sv
      - source/mips.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tbClock.sv
      - sim/mipsTb.sv

/* include/mipsSys_config.svh */
// Address map and sizing for the MIPS memory-mapped system
// Memory sits at the bottom of the map; devices live in a 256-byte window
// Timer register offsets are word offsets within a 16-byte timer block
// Control register: bit 0 enable, bits 2:1 mode, bit 3 interrupt mask
`ifndef MIPSSYS_CONFIG_SVH
`define MIPSSYS_CONFIG_SVH

// Data memory, 4 KiB of 32-bit words
`define DM_WORDS    1024
`define DM_BASE     32'h0000_0000
`define DM_LIMIT    32'h0000_0FFF

// Device window and the two timer blocks inside it
`define DEV_BASE    32'h0000_7F00
`define TIMER0_BASE 32'h0000_7F00
`define TIMER1_BASE 32'h0000_7F10
`define TIMER_SPAN  16

// Timer register word offsets
`define REG_CTRL    2'd0
`define REG_PRESET  2'd1
`define REG_COUNT   2'd2

`endif

/* sim/mipsTb.sv */
// Directed testbench for the mips memory-mapped system
// The testbench acts as the CPU load/store unit on the request/response ports
// Memory is never reset, so each checked word gets a full write first
// Inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module mipsTb;

`include "mipsSys_config.svh"

    localparam int MaxCycles = 20000;

    logic        clk;
    logic        rstN;
    logic        extInt;
    logic        reqValid;
    logic        rspReady;
    logic        reqReady;
    logic        rspValid;
    logic [31:0] reqAddr;
    logic [31:0] reqWdata;
    logic [31:0] rspRdata;
    logic [3:0]  reqBe;
    logic [7:2]  hwInt;
    logic [15:0] lfsrState;
    logic [31:0] refMem [`DM_WORDS];
    int          cycleCount = 0;

    tbClock u_tbClock (.clk(clk));

    mips u_dut (.*);

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            stopWithFailure($sformatf("ERROR %s: expected 0x%08h, got 0x%08h",
                                      name, expected, actual));
        end
    endtask

    // 16-bit Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic randBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // Reference byte-lane merge
    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] wdata,
                                               input logic [3:0] be);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] timerReg(input int unit, input logic [1:0] off);
        return ((unit == 0) ? `TIMER0_BASE : `TIMER1_BASE) + {28'b0, off, 2'b00};
    endfunction

    task automatic waitReady();
        @(negedge clk);
        while (!reqReady) begin
            @(negedge clk);
        end
    endtask

    // Drives one request and samples its response one cycle after acceptance
    task automatic transfer(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
        @(posedge clk);
        reqValid <= 1'b1;
        reqAddr  <= addr;
        reqWdata <= wdata;
        reqBe    <= be;
        rspReady <= 1'b1;
        waitReady();
        @(posedge clk);
        reqValid <= 1'b0;
        @(negedge clk);
        checkEq("rspValid", 32'd1, rspValid);
        rdata = rspRdata;
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be);
        logic [31:0] rdata;
        transfer(addr, wdata, be, rdata);
        checkEq("rspRdata", 32'd0, rdata);
    endtask

    task automatic busRead(input logic [31:0] addr, output logic [31:0] rdata);
        transfer(addr, 32'd0, 4'h0, rdata);
    endtask

    // Waits up to maxCycles falling edges for one hwInt bit to reach a value
    task automatic waitIrq(input int bitIdx, input logic value, input int maxCycles);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hwInt[bitIdx] !== value) begin
            if (cycles >= maxCycles) begin
                stopWithFailure($sformatf("hwInt bit %0d did not become %0b within %0d cycles",
                                          bitIdx, value, maxCycles));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic memoryReadback();
        logic [31:0] addrList [32];
        logic [31:0] idx;
        logic [31:0] data;
        logic [31:0] beBits;
        logic [31:0] got;
        for (int i = 0; i < 32; i++) begin
            randBits(10, idx);
            addrList[i] = `DM_BASE + {idx[29:0], 2'b00};
            randBits(32, data);
            busWrite(addrList[i], data, 4'hF);
            refMem[idx[9:0]] = data;
            beBits = '0;
            while (beBits[3:0] == 4'h0) begin
                randBits(4, beBits);
            end
            randBits(32, data);
            busWrite(addrList[i], data, beBits[3:0]);
            refMem[idx[9:0]] = mergeBytes(refMem[idx[9:0]], data, beBits[3:0]);
        end
        for (int i = 0; i < 32; i++) begin
            busRead(addrList[i], got);
            checkEq("rspRdata", refMem[addrList[i][11:2]], got);
        end
    endtask

    task automatic responseStall();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] got;
        randBits(32, first);
        randBits(32, second);
        busWrite(32'h0000_0100, first, 4'hF);
        @(posedge clk);
        reqValid <= 1'b1;
        reqAddr  <= 32'h0000_0100;
        reqBe    <= 4'h0;
        rspReady <= 1'b0;
        waitReady();
        @(posedge clk);
        // A write queued behind the stalled read response
        reqBe    <= 4'hF;
        reqWdata <= second;
        repeat (5) begin
            @(negedge clk);
            checkEq("rspValid", 32'd1, rspValid);
            checkEq("reqReady", 32'd0, reqReady);
            checkEq("rspRdata", first, rspRdata);
        end
        @(posedge clk);
        rspReady <= 1'b1;
        @(negedge clk);
        checkEq("reqReady", 32'd1, reqReady);
        @(posedge clk);
        reqValid <= 1'b0;
        @(negedge clk);
        checkEq("rspValid", 32'd1, rspValid);
        checkEq("rspRdata", 32'd0, rspRdata);
        busRead(32'h0000_0100, got);
        checkEq("rspRdata", second, got);
    endtask

    task automatic unmappedAccess();
        logic [31:0] got;
        // Nonzero presets so a read that leaks into a timer shows up
        busWrite(timerReg(0, `REG_PRESET), 32'h0000_5A5A, 4'hF);
        busWrite(timerReg(1, `REG_PRESET), 32'h0000_A5A5, 4'hF);
        busWrite(32'h0000_0040, 32'hA5C3_0F96, 4'hF);
        busWrite(32'h0001_0040, 32'h1234_5678, 4'hF);
        busRead(32'h0000_0040, got);
        checkEq("rspRdata", 32'hA5C3_0F96, got);
        busRead(32'h0001_0040, got);
        checkEq("rspRdata", 32'd0, got);
        busRead(32'h8000_0000, got);
        checkEq("rspRdata", 32'd0, got);
        busRead(`DEV_BASE + 32'h24, got);
        checkEq("rspRdata", 32'd0, got);
        busRead(timerReg(0, 2'd3), got);
        checkEq("rspRdata", 32'd0, got);
    endtask

    task automatic timerRegisters();
        logic [31:0] presetVal;
        logic [31:0] c1;
        logic [31:0] c2;
        logic [31:0] got;
        randBits(32, presetVal);
        busWrite(timerReg(0, `REG_PRESET), presetVal, 4'hF);
        busWrite(timerReg(0, `REG_PRESET), ~presetVal, 4'h3);
        busRead(timerReg(0, `REG_PRESET), got);
        checkEq("timer0 preset", presetVal, got);
        busWrite(timerReg(0, `REG_COUNT), 32'h1234, 4'hF);
        busRead(timerReg(0, `REG_COUNT), got);
        checkEq("timer0 count", 32'd0, got);
        // One-shot with the interrupt mask clear
        busWrite(timerReg(0, `REG_PRESET), 32'd300, 4'hF);
        busWrite(timerReg(0, `REG_CTRL), 32'h1, 4'hF);
        busRead(timerReg(0, `REG_COUNT), c1);
        busRead(timerReg(0, `REG_COUNT), c2);
        checkEq("timer0 count decreasing", 32'd1, c2 < c1);
        while (c2 != 32'd0) begin
            busRead(timerReg(0, `REG_COUNT), c2);
        end
        busRead(timerReg(0, `REG_CTRL), got);
        checkEq("timer0 ctrl", 32'd0, got);
    endtask

    task automatic interruptLines();
        checkEq("hwInt[2]", 32'd0, hwInt[2]);
        busWrite(timerReg(0, `REG_PRESET), 32'd40, 4'hF);
        busWrite(timerReg(0, `REG_CTRL), 32'h9, 4'hF);
        waitIrq(2, 1'b1, 50);
        busWrite(timerReg(0, `REG_CTRL), 32'h0, 4'hF);
        waitIrq(2, 1'b0, 4);
        // Reload mode with enable and the interrupt mask set
        busWrite(timerReg(1, `REG_PRESET), 32'd20, 4'hF);
        busWrite(timerReg(1, `REG_CTRL), 32'hB, 4'hF);
        repeat (3) begin
            waitIrq(3, 1'b1, 30);
            waitIrq(3, 1'b0, 2);
        end
        busWrite(timerReg(1, `REG_CTRL), 32'h0, 4'hF);
        @(posedge clk);
        extInt <= 1'b1;
        waitIrq(4, 1'b1, 2);
        @(posedge clk);
        extInt <= 1'b0;
        waitIrq(4, 1'b0, 2);
    endtask

    // Cause bits 7:5 have no source and must read zero
    always @(negedge clk) begin
        if (rstN) begin
            checkEq("hwInt[7:5]", 32'd0, hwInt[7:5]);
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            stopWithFailure($sformatf("Timeout: the run did not finish in %0d cycles",
                                      MaxCycles));
        end
    end

    initial begin
        lfsrState = 16'd51941;
        rstN      = 1'b0;
        extInt    = 1'b0;
        reqValid  = 1'b0;
        reqAddr   = '0;
        reqWdata  = '0;
        reqBe     = '0;
        rspReady  = 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkEq("reqReady", 32'd0, reqReady);
        checkEq("rspValid", 32'd0, rspValid);
        checkEq("hwInt", 32'd0, hwInt);
        memoryReadback();
        responseStall();
        unmappedAccess();
        timerRegisters();
        interruptLines();
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* sim/tbClock.sv */
// Free-running testbench clock, 8 ns period
// Starts low at time zero
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

/* source/dataMem.sv */
// Word-addressed data memory with byte-enabled writes
// Only address bits 11:2 are used, so the array aliases above 4 KiB
// Reads are combinational; contents are undefined after reset
`timescale 1ns/1ps

module dataMem (
    input  logic   clk,
    slaveIf.slave  bus
);

`include "mipsSys_config.svh"

    localparam int AddrW = $clog2(`DM_WORDS);

    logic [31:0]      mem [`DM_WORDS];
    logic [AddrW-1:0] wordIdx;

    assign wordIdx = bus.addr[AddrW+1:2];

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        if (bus.sel) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.be[i]) begin
                    mem[wordIdx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    assign bus.rdata = mem[wordIdx];

endmodule

/* source/mips.sv */
// Top level of the memory-mapped system around a MIPS core
// The CPU is external: its load/store port appears as plain
// valid/ready request and response channels
// A request with reqBe of zero is a read, otherwise a byte-enabled write
// hwInt carries cause bits 7:2, two registers behind the sources
`timescale 1ns/1ps

module mips (
    input  logic        clk,
    input  logic        rstN,
    input  logic        extInt,
    input  logic        reqValid,
    input  logic [31:0] reqAddr,
    input  logic [31:0] reqWdata,
    input  logic [3:0]  reqBe,
    output logic        reqReady,
    output logic        rspValid,
    output logic [31:0] rspRdata,
    input  logic        rspReady,
    output logic [7:2]  hwInt
);

    // Bridge to memory and bridge to bridge
    slaveIf memIf ();
    slaveIf southIf ();

    // South bridge to the timers
    slaveIf t0If ();
    slaveIf t1If ();

    logic       t0Irq;
    logic       t1Irq;
    logic [7:2] sbHwInt;

    northBridge u_northBridge (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .reqAddr  (reqAddr),
        .reqWdata (reqWdata),
        .reqBe    (reqBe),
        .reqReady (reqReady),
        .rspValid (rspValid),
        .rspRdata (rspRdata),
        .rspReady (rspReady),
        .memIf    (memIf.master),
        .southIf  (southIf.master),
        .irqIn    (sbHwInt),
        .hwInt    (hwInt)
    );

    dataMem u_dataMem (
        .clk (clk),
        .bus (memIf.slave)
    );

    southBridge u_southBridge (
        .clk    (clk),
        .rstN   (rstN),
        .extInt (extInt),
        .t0Irq  (t0Irq),
        .t1Irq  (t1Irq),
        .up     (southIf.slave),
        .t0     (t0If.master),
        .t1     (t1If.master),
        .hwInt  (sbHwInt)
    );

    timer u_timer0 (
        .clk  (clk),
        .rstN (rstN),
        .bus  (t0If.slave),
        .irq  (t0Irq)
    );

    timer u_timer1 (
        .clk  (clk),
        .rstN (rstN),
        .bus  (t1If.slave),
        .irq  (t1Irq)
    );

endmodule

/* source/mipsPkg.sv */
// Shared types for the MIPS memory-mapped system
// Timer mode values 2 and 3 are not named and behave as one-shot
package mipsPkg;

    // Where an accepted CPU request is routed
    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_SOUTH,
        TGT_NONE
    } busTargetE;

    // Timer operating mode, control bits 2:1
    typedef enum logic [1:0] {
        MODE_ONESHOT = 2'd0,
        MODE_RELOAD  = 2'd1
    } timerModeE;

    // Timer counter FSM
    typedef enum logic [1:0] {
        T_IDLE,
        T_LOAD,
        T_COUNT,
        T_DONE
    } timerStateE;

endpackage

/* source/northBridge.sv */
// CPU-facing bridge with one response register
// A request is decoded, sent to one slave and answered the next cycle
// Only one response can be pending; reqReady drops under back-pressure
// Unmapped reads return zero and unmapped writes are dropped
`timescale 1ns/1ps

module northBridge import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        reqValid,
    input  logic [31:0] reqAddr,
    input  logic [31:0] reqWdata,
    input  logic [3:0]  reqBe,
    output logic        reqReady,
    output logic        rspValid,
    output logic [31:0] rspRdata,
    input  logic        rspReady,
    slaveIf.master      memIf,
    slaveIf.master      southIf,
    input  logic [7:2]  irqIn,
    output logic [7:2]  hwInt
);

`include "mipsSys_config.svh"

    localparam logic [31:0] DevBase = `DEV_BASE;

    logic        outOfReset;
    logic        accept;
    logic        isWrite;
    busTargetE   target;
    logic [31:0] readData;

    // Ready is held low for the whole reset period
    assign reqReady = outOfReset && (!rspValid || rspReady);
    assign accept   = reqValid && reqReady;
    assign isWrite  = |reqBe;

    // Address decode
    always_comb begin
        if ((reqAddr - `DM_BASE) <= (`DM_LIMIT - `DM_BASE)) begin
            target = TGT_MEM;
        end else if (reqAddr[31:8] == DevBase[31:8]) begin
            target = TGT_SOUTH;
        end else begin
            target = TGT_NONE;
        end
    end

    // Request fields go straight to both slaves, only sel is steered
    assign memIf.sel     = accept && (target == TGT_MEM);
    assign memIf.be      = reqBe;
    assign memIf.addr    = reqAddr;
    assign memIf.wdata   = reqWdata;

    assign southIf.sel   = accept && (target == TGT_SOUTH);
    assign southIf.be    = reqBe;
    assign southIf.addr  = reqAddr;
    assign southIf.wdata = reqWdata;

    // Read data mux, writes answer with zero
    always_comb begin
        readData = '0;
        if (!isWrite) begin
            case (target)
                TGT_MEM:   readData = memIf.rdata;
                TGT_SOUTH: readData = southIf.rdata;
                default:   readData = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outOfReset <= 1'b0;
            rspValid   <= 1'b0;
            hwInt      <= '0;
        end else begin
            outOfReset <= 1'b1;
            hwInt      <= irqIn;
            if (accept) begin
                rspValid <= 1'b1;
            end else if (rspReady) begin
                rspValid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            rspRdata <= readData;
        end
    end

endmodule

/* source/slaveIf.sv */
// Single-cycle slave port used between bridges, memory and timers
// sel is high for one cycle per access; be of zero marks a read
// rdata must be combinational and valid in the same cycle as sel
`timescale 1ns/1ps

interface slaveIf;

    logic        sel;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;

    modport master (
        output sel,
        output be,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  sel,
        input  be,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

/* source/southBridge.sv */
// Device-side bridge for the two timers
// Addresses in the device window that miss both timers read zero
// and their writes are dropped
// hwInt is registered once here: timer 0 on bit 2, timer 1 on bit 3,
// extInt on bit 4, bits 7:5 tied to zero
`timescale 1ns/1ps

module southBridge (
    input  logic       clk,
    input  logic       rstN,
    input  logic       extInt,
    input  logic       t0Irq,
    input  logic       t1Irq,
    slaveIf.slave      up,
    slaveIf.master     t0,
    slaveIf.master     t1,
    output logic [7:2] hwInt
);

`include "mipsSys_config.svh"

    logic [31:0] t0Off;
    logic [31:0] t1Off;
    logic        t0Hit;
    logic        t1Hit;

    // Offsets within each timer block
    assign t0Off = up.addr - `TIMER0_BASE;
    assign t1Off = up.addr - `TIMER1_BASE;
    assign t0Hit = t0Off < `TIMER_SPAN;
    assign t1Hit = t1Off < `TIMER_SPAN;

    // Timer 0 port
    assign t0.sel   = up.sel && t0Hit;
    assign t0.be    = up.be;
    assign t0.addr  = t0Off;
    assign t0.wdata = up.wdata;

    // Timer 1 port
    assign t1.sel   = up.sel && t1Hit;
    assign t1.be    = up.be;
    assign t1.addr  = t1Off;
    assign t1.wdata = up.wdata;

    always_comb begin
        if (t0Hit) begin
            up.rdata = t0.rdata;
        end else if (t1Hit) begin
            up.rdata = t1.rdata;
        end else begin
            up.rdata = '0;
        end
    end

    // Interrupt collection
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hwInt <= '0;
        end else begin
            hwInt <= {3'b000, extInt, t1Irq, t0Irq};
        end
    end

endmodule

/* source/timer.sv */
// Programmable down-counter with control, preset and count registers
// Only full-word writes change a register; count is read-only
// One-shot holds irq until the next control write, reload pulses it
// irq is only raised when the mask bit (control bit 3) is set
`timescale 1ns/1ps

module timer import mipsPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    slaveIf.slave bus,
    output logic  irq
);

`include "mipsSys_config.svh"

    // Control register bit positions
    localparam int EnBit   = 0;
    localparam int ModeLsb = 1;
    localparam int MaskBit = 3;

    timerStateE  state;
    logic        ctrlEn;
    logic [1:0]  ctrlMode;
    logic        ctrlMask;
    logic [31:0] preset;
    logic [31:0] count;
    logic [1:0]  regOff;
    logic        fullWrite;
    logic        ctrlWrite;
    logic        presetWrite;

    assign regOff      = bus.addr[3:2];
    assign fullWrite   = bus.sel && (bus.be == 4'hF);
    assign ctrlWrite   = fullWrite && (regOff == `REG_CTRL);
    assign presetWrite = fullWrite && (regOff == `REG_PRESET);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= T_IDLE;
            ctrlEn   <= 1'b0;
            ctrlMode <= '0;
            ctrlMask <= 1'b0;
            preset   <= '0;
            count    <= '0;
        end else begin
            if (presetWrite) begin
                preset <= bus.wdata;
            end
            if (ctrlWrite) begin
                // A control write restarts or stops the counter
                ctrlEn   <= bus.wdata[EnBit];
                ctrlMode <= bus.wdata[ModeLsb +: 2];
                ctrlMask <= bus.wdata[MaskBit];
                state    <= bus.wdata[EnBit] ? T_LOAD : T_IDLE;
            end else begin
                case (state)
                    T_LOAD: begin
                        count <= preset;
                        state <= T_COUNT;
                    end
                    T_COUNT: begin
                        if (count <= 32'd1) begin
                            count <= '0;
                            state <= T_DONE;
                        end else begin
                            count <= count - 32'd1;
                        end
                    end
                    T_DONE: begin
                        if (ctrlMode == MODE_RELOAD) begin
                            state <= T_LOAD;
                        end else begin
                            // One-shot, park here until software rewrites control
                            ctrlEn <= 1'b0;
                        end
                    end
                    default: state <= T_IDLE;
                endcase
            end
        end
    end

    assign irq = (state == T_DONE) && ctrlMask;

    // Register read back
    always_comb begin
        case (regOff)
            `REG_CTRL:   bus.rdata = {28'b0, ctrlMask, ctrlMode, ctrlEn};
            `REG_PRESET: bus.rdata = preset;
            `REG_COUNT:  bus.rdata = count;
            default:     bus.rdata = '0;
        endcase
    end

endmodule

/* tb.f */
+incdir+include
source/mipsPkg.sv
source/slaveIf.sv
source/dataMem.sv
source/timer.sv
source/southBridge.sv
source/northBridge.sv
source/mips.sv
sim/tbClock.sv
sim/mipsTb.sv
